/* hdl/stats_config.svh */
// Frame length limits and counter width shared by the receive statistics RTL, pulled in by `include
`ifndef STATS_CONFIG_SVH
`define STATS_CONFIG_SVH

// Width of every statistics counter
`define STAT_COUNT_W 32

// Good frame length bounds in bytes, counted after the delimiter
`define MIN_FRAME_LEN 64
`define MAX_FRAME_LEN 1518

// Width of a measured frame length
// Must hold MAX_FRAME_LEN + 1, the saturation value
`define LEN_W 16

`endif

/* hdl/stats_pkg.sv */
// Types shared by the statistics RTL and testbench, referenced by scoped name
`include "stats_config.svh"

package stats_pkg;

    // Frame length as measured by a receive monitor
    typedef logic [`LEN_W-1:0] frame_len_t;

    // Counter selector, low two bits of the read address
    typedef enum logic [1:0] {
        STAT_GOOD_FRAMES = 2'd0,
        STAT_BAD_FRAMES  = 2'd1,
        STAT_RUNT_FRAMES = 2'd2,
        STAT_GOOD_BYTES  = 2'd3
    } stat_sel_e;

    // Port selector, top bit of the read address
    typedef enum logic {
        PORT_BASET = 1'b0,
        PORT_SFP   = 1'b1
    } stat_port_e;

endpackage

/* hdl/frame_stat_if.sv */
// Per-frame summary link from a receive monitor into the counter bank
`timescale 1ns/10ps

interface frame_stat_if;

    // One-cycle strobe, no back-pressure
    logic                  valid;
    logic                  good;
    logic                  runt;
    stats_pkg::frame_len_t len;

    modport src (
        output valid,
        output good,
        output runt,
        output len
    );

    modport sink (
        input valid,
        input good,
        input runt,
        input len
    );

endinterface

/* hdl/gmii_rx_monitor.sv */
// GMII receive monitor for one port, delimits frames and emits one length summary per frame
`timescale 1ns/10ps
`include "stats_config.svh"

module gmii_rx_monitor (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       gmii_clk_en,
    input  logic [7:0] gmii_rxd,
    input  logic       gmii_rx_dv,
    input  logic       gmii_rx_er,
    frame_stat_if.src  stat
);

    localparam logic [7:0] SFD = 8'hD5;

    localparam stats_pkg::frame_len_t LEN_MIN = stats_pkg::frame_len_t'(`MIN_FRAME_LEN);
    localparam stats_pkg::frame_len_t LEN_MAX = stats_pkg::frame_len_t'(`MAX_FRAME_LEN);
    // Counting stops here, enough to flag oversize
    localparam stats_pkg::frame_len_t LEN_SAT = stats_pkg::frame_len_t'(`MAX_FRAME_LEN + 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PREAMBLE,
        ST_DATA
    } state_e;

    state_e                state;
    logic                  err_seen;
    stats_pkg::frame_len_t len_cnt;
    logic                  frame_end;
    logic                  frame_bad;
    logic                  frame_runt;

    // First enabled sample with rx_dv low closes the frame
    assign frame_end = gmii_clk_en && !gmii_rx_dv && (state != ST_IDLE);

    // Still in preamble at the end means no delimiter arrived
    assign frame_bad  = err_seen || (state == ST_PREAMBLE) || (len_cnt > LEN_MAX);
    assign frame_runt = !frame_bad && (len_cnt < LEN_MIN);

    // Delimiter tracking and error flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            err_seen <= 1'b0;
        end else if (gmii_clk_en) begin
            case (state)
                ST_IDLE: begin
                    if (gmii_rx_dv) begin
                        err_seen <= gmii_rx_er;
                        // Frame may open directly on the delimiter
                        state    <= (gmii_rxd == SFD) ? ST_DATA : ST_PREAMBLE;
                    end
                end
                ST_PREAMBLE: begin
                    if (!gmii_rx_dv) begin
                        state <= ST_IDLE;
                    end else begin
                        err_seen <= err_seen | gmii_rx_er;
                        if (gmii_rxd == SFD) begin
                            state <= ST_DATA;
                        end
                    end
                end
                ST_DATA: begin
                    if (!gmii_rx_dv) begin
                        state <= ST_IDLE;
                    end else begin
                        err_seen <= err_seen | gmii_rx_er;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Saturating byte count after the delimiter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            len_cnt <= '0;
        end else if (gmii_clk_en) begin
            if (state == ST_IDLE) begin
                len_cnt <= '0;
            end else if (state == ST_DATA && gmii_rx_dv && len_cnt != LEN_SAT) begin
                len_cnt <= len_cnt + 1'b1;
            end
        end
    end

    // Summary strobe, one cycle after the end sample
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stat.valid <= 1'b0;
            stat.good  <= 1'b0;
            stat.runt  <= 1'b0;
        end else begin
            stat.valid <= frame_end;
            if (frame_end) begin
                stat.good <= !frame_bad && !frame_runt;
                stat.runt <= frame_runt;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (frame_end) begin
            stat.len <= len_cnt;
        end
    end

    // A frame needs at least one sample besides its end
    assert property (@(posedge clk) disable iff (!rst_n) stat.valid |=> !stat.valid)
        else $error("summary strobe held for two cycles");

    // Good class and reported length come from separate registers
    assert property (@(posedge clk) disable iff (!rst_n)
        stat.valid && stat.good |-> (stat.len >= LEN_MIN && stat.len <= LEN_MAX))
        else $error("good frame reported with a length outside the legal range");

endmodule

/* hdl/stat_counter_bank.sv */
// Counter bank for both ports' frame summaries, with a registered read port and a clear
`timescale 1ns/10ps
`include "stats_config.svh"

module stat_counter_bank (
    input  logic                     clk,
    input  logic                     rst_n,
    frame_stat_if.sink               baset_stat,
    frame_stat_if.sink               sfp_stat,
    input  logic                     stat_clear,
    input  logic [2:0]               stat_addr,
    output logic [`STAT_COUNT_W-1:0] stat_data
);

    localparam int COUNT_W = `STAT_COUNT_W;
    localparam int PORTS   = 2;
    localparam int STATS   = 4;

    logic                  in_valid [PORTS];
    logic                  in_good  [PORTS];
    logic                  in_runt  [PORTS];
    stats_pkg::frame_len_t in_len   [PORTS];

    logic [COUNT_W-1:0]    counter  [PORTS][STATS];

    stats_pkg::stat_port_e rd_port;
    stats_pkg::stat_sel_e  rd_sel;

    // Both sinks as one array indexed by port
    assign in_valid[stats_pkg::PORT_BASET] = baset_stat.valid;
    assign in_good[stats_pkg::PORT_BASET]  = baset_stat.good;
    assign in_runt[stats_pkg::PORT_BASET]  = baset_stat.runt;
    assign in_len[stats_pkg::PORT_BASET]   = baset_stat.len;
    assign in_valid[stats_pkg::PORT_SFP]   = sfp_stat.valid;
    assign in_good[stats_pkg::PORT_SFP]    = sfp_stat.good;
    assign in_runt[stats_pkg::PORT_SFP]    = sfp_stat.runt;
    assign in_len[stats_pkg::PORT_SFP]     = sfp_stat.len;

    // Each port has its own adders, so both can update in one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int p = 0; p < PORTS; p++) begin
                for (int s = 0; s < STATS; s++) begin
                    counter[p][s] <= '0;
                end
            end
        end else if (stat_clear) begin
            // Clear takes priority over a pending update
            for (int p = 0; p < PORTS; p++) begin
                for (int s = 0; s < STATS; s++) begin
                    counter[p][s] <= '0;
                end
            end
        end else begin
            for (int p = 0; p < PORTS; p++) begin
                if (in_valid[p]) begin
                    if (in_good[p]) begin
                        counter[p][stats_pkg::STAT_GOOD_FRAMES] <=
                            counter[p][stats_pkg::STAT_GOOD_FRAMES] + 1'b1;
                        counter[p][stats_pkg::STAT_GOOD_BYTES] <=
                            counter[p][stats_pkg::STAT_GOOD_BYTES] + COUNT_W'(in_len[p]);
                    end else if (in_runt[p]) begin
                        counter[p][stats_pkg::STAT_RUNT_FRAMES] <=
                            counter[p][stats_pkg::STAT_RUNT_FRAMES] + 1'b1;
                    end else begin
                        counter[p][stats_pkg::STAT_BAD_FRAMES] <=
                            counter[p][stats_pkg::STAT_BAD_FRAMES] + 1'b1;
                    end
                end
            end
        end
    end

    // Port in the top address bit, counter select below
    assign rd_port = stats_pkg::stat_port_e'(stat_addr[2]);
    assign rd_sel  = stats_pkg::stat_sel_e'(stat_addr[1:0]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stat_data <= '0;
        end else begin
            stat_data <= counter[rd_port][rd_sel];
        end
    end

    // Monitors must hand over exclusive classes
    for (genvar p = 0; p < PORTS; p++) begin : g_sum_chk
        assert property (@(posedge clk) disable iff (!rst_n)
            in_valid[p] |-> !(in_good[p] && in_runt[p]))
            else $error("summary on port %0d is both good and runt", p);
    end

endmodule

/* hdl/eth_stats_core.sv */
// Receive statistics top level for the BASE-T and SFP ports, read through a small address port
`timescale 1ns/10ps
`include "stats_config.svh"

module eth_stats_core (
    input  logic                     clk,
    input  logic                     rst_n,

    // BASE-T PHY receive
    input  logic [7:0]               baset_gmii_rxd,
    input  logic                     baset_gmii_rx_dv,
    input  logic                     baset_gmii_rx_er,
    input  logic                     baset_gmii_clk_en,

    // SFP receive
    input  logic [7:0]               sfp_gmii_rxd,
    input  logic                     sfp_gmii_rx_dv,
    input  logic                     sfp_gmii_rx_er,
    input  logic                     sfp_gmii_clk_en,

    // Counter access
    input  logic                     stat_clear,
    input  logic [2:0]               stat_addr,
    output logic [`STAT_COUNT_W-1:0] stat_data
);

    frame_stat_if baset_stat_if ();
    frame_stat_if sfp_stat_if ();

    gmii_rx_monitor baset_mon_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .gmii_clk_en (baset_gmii_clk_en),
        .gmii_rxd    (baset_gmii_rxd),
        .gmii_rx_dv  (baset_gmii_rx_dv),
        .gmii_rx_er  (baset_gmii_rx_er),
        .stat        (baset_stat_if.src)
    );

    gmii_rx_monitor sfp_mon_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .gmii_clk_en (sfp_gmii_clk_en),
        .gmii_rxd    (sfp_gmii_rxd),
        .gmii_rx_dv  (sfp_gmii_rx_dv),
        .gmii_rx_er  (sfp_gmii_rx_er),
        .stat        (sfp_stat_if.src)
    );

    stat_counter_bank counter_bank_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .baset_stat (baset_stat_if.sink),
        .sfp_stat   (sfp_stat_if.sink),
        .stat_clear (stat_clear),
        .stat_addr  (stat_addr),
        .stat_data  (stat_data)
    );

endmodule

/* verification/tb_eth_stats_core.sv */
// Directed testbench for eth_stats_core, drives GMII frames on both ports and checks the counters
`timescale 1ns/10ps
`include "stats_config.svh"

module tb_eth_stats_core;

    localparam int CLK_PERIOD = 100;
    // Payload bytes of every frame below, the alternate-enable frame counted twice
    localparam int TOTAL_BYTES = 100 + 40 + (`MAX_FRAME_LEN + 12) + 80 + 70 + 200 + 2 * 120 + 90;
    localparam int MARGIN_CYCLES = 1000;

    logic                     clk;
    logic                     rst_n;
    logic [7:0]               rxd [2];
    logic                     dv  [2];
    logic                     er  [2];
    logic                     en  [2];
    logic                     stat_clear;
    logic [2:0]               stat_addr;
    logic [`STAT_COUNT_W-1:0] stat_data;

    logic [`STAT_COUNT_W-1:0] exp_cnt [2][4];
    integer                   seed;
    int                       error_count;
    int                       pass_count;
    int                       fail_count;

    // Index 0 is the BASE-T port, index 1 the SFP port
    eth_stats_core dut (
        .clk               (clk),
        .rst_n             (rst_n),
        .baset_gmii_rxd    (rxd[0]),
        .baset_gmii_rx_dv  (dv[0]),
        .baset_gmii_rx_er  (er[0]),
        .baset_gmii_clk_en (en[0]),
        .sfp_gmii_rxd      (rxd[1]),
        .sfp_gmii_rx_dv    (dv[1]),
        .sfp_gmii_rx_er    (er[1]),
        .sfp_gmii_clk_en   (en[1]),
        .stat_clear        (stat_clear),
        .stat_addr         (stat_addr),
        .stat_data         (stat_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input logic [`STAT_COUNT_W-1:0] actual,
                               input logic [`STAT_COUNT_W-1:0] expected, input string msg);
        if (actual !== expected) begin
            $display("FAILED at time %0t: %s, got %0d, expected %0d", $time, msg, actual, expected);
            error_count++;
        end
    endtask

    // Expected counters from the frame classification rules
    task automatic model_frame(input int port, input int len, input bit with_sfd, input bit with_err);
        if (with_err || !with_sfd || len > `MAX_FRAME_LEN) begin
            exp_cnt[port][stats_pkg::STAT_BAD_FRAMES] += 1;
        end else if (len < `MIN_FRAME_LEN) begin
            exp_cnt[port][stats_pkg::STAT_RUNT_FRAMES] += 1;
        end else begin
            exp_cnt[port][stats_pkg::STAT_GOOD_FRAMES] += 1;
            exp_cnt[port][stats_pkg::STAT_GOOD_BYTES] += `STAT_COUNT_W'(len);
        end
    endtask

    // en_pat bit 0 applies to even cycles, bit 1 to odd ones; err_at < 0 means no rx_er
    task automatic send_frame(input int port, input int len, input bit with_sfd,
                              input int err_at, input logic [1:0] en_pat);
        logic [7:0] stream [$];
        logic [7:0] b;
        int         idx;
        int         cyc;
        idx = 0;
        cyc = 0;
        for (int i = 0; i < 7; i++) begin
            stream.push_back(8'h55);
        end
        if (with_sfd) begin
            stream.push_back(8'hD5);
        end
        for (int i = 0; i < len; i++) begin
            b = 8'($random(seed));
            // No stray delimiter in a frame meant to lack one
            if (!with_sfd && b == 8'hD5) begin
                b = 8'h00;
            end
            stream.push_back(b);
        end
        while (idx < stream.size()) begin
            en[port] = en_pat[cyc % 2];
            if (en_pat[cyc % 2]) begin
                rxd[port] = stream[idx];
                dv[port]  = 1'b1;
                er[port]  = (idx == err_at);
                idx++;
            end
            cyc++;
            @(posedge clk);
            #10;
        end
        // Enabled sample with rx_dv low ends the frame
        en[port]  = 1'b1;
        dv[port]  = 1'b0;
        er[port]  = 1'b0;
        rxd[port] = 8'h00;
        repeat (2) begin
            @(posedge clk);
            #10;
        end
        model_frame(port, len, with_sfd, err_at >= 0);
    endtask

    task automatic read_stat(input logic [2:0] addr, output logic [`STAT_COUNT_W-1:0] value);
        stat_addr = addr;
        @(posedge clk);
        #10;
        value = stat_data;
    endtask

    task automatic check_all_counters();
        logic [`STAT_COUNT_W-1:0] value;
        for (int p = 0; p < 2; p++) begin
            for (int s = 0; s < 4; s++) begin
                read_stat({1'(p), 2'(s)}, value);
                check_value(value, exp_cnt[p][s], $sformatf("port %0d counter %0d", p, s));
            end
        end
    endtask

    task automatic clear_counters();
        stat_clear = 1'b1;
        @(posedge clk);
        #10;
        stat_clear = 1'b0;
        for (int p = 0; p < 2; p++) begin
            for (int s = 0; s < 4; s++) begin
                exp_cnt[p][s] = '0;
            end
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            $display("Test %s: ok", name);
            pass_count++;
        end else begin
            $display("Test %s: %0d mismatches", name, error_count - errors_before);
            fail_count++;
        end
    endtask

    task automatic test_reset_values();
        int errs;
        errs = error_count;
        check_all_counters();
        report_test("reset_values", errs);
    endtask

    task automatic test_baset_classes();
        int errs;
        errs = error_count;
        send_frame(0, 100, 1'b1, -1, 2'b11);
        send_frame(0, 40, 1'b1, -1, 2'b11);
        send_frame(0, `MAX_FRAME_LEN + 12, 1'b1, -1, 2'b11);
        check_all_counters();
        report_test("baset_classes", errs);
    endtask

    task automatic test_sfp_bad_frames();
        int errs;
        errs = error_count;
        send_frame(1, 80, 1'b1, 20, 2'b11);
        send_frame(1, 70, 1'b0, -1, 2'b11);
        check_all_counters();
        report_test("sfp_bad_frames", errs);
    endtask

    task automatic test_both_ports();
        int errs;
        errs = error_count;
        // Same length and start, so both frames end in one cycle
        fork
            send_frame(0, 200, 1'b1, -1, 2'b11);
            send_frame(1, 200, 1'b1, -1, 2'b11);
        join
        send_frame(0, 120, 1'b1, -1, 2'b01);
        check_all_counters();
        report_test("both_ports", errs);
    endtask

    task automatic test_clear();
        int errs;
        errs = error_count;
        clear_counters();
        check_all_counters();
        send_frame(1, 90, 1'b1, -1, 2'b11);
        check_all_counters();
        report_test("clear", errs);
    endtask

    initial begin
        #((TOTAL_BYTES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Watchdog expired, the run timed out before all tests finished");
        $display("Regression failed");
        $finish;
    end

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        stat_clear  = 1'b0;
        stat_addr   = 3'd0;
        seed        = 74;
        error_count = 0;
        pass_count  = 0;
        fail_count  = 0;
        for (int p = 0; p < 2; p++) begin
            rxd[p] = 8'h00;
            dv[p]  = 1'b0;
            er[p]  = 1'b0;
            en[p]  = 1'b1;
            for (int s = 0; s < 4; s++) begin
                exp_cnt[p][s] = '0;
            end
        end
        repeat (2) @(posedge clk);
        #10;
        rst_n = 1'b1;

        test_reset_values();
        test_baset_classes();
        test_sfp_bad_frames();
        test_both_ports();
        test_clear();

        $display("Tests: %0d passed, %0d failed, %0d mismatches", pass_count, fail_count,
                 error_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+hdl
hdl/stats_pkg.sv
hdl/frame_stat_if.sv
hdl/gmii_rx_monitor.sv
hdl/stat_counter_bank.sv
hdl/eth_stats_core.sv
verification/tb_eth_stats_core.sv

/* Makefile */
.PHONY: sim clean

# Build with Verilator, run, and fail unless the pass message was printed
sim:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_eth_stats_core
	@out="$$(./obj_dir/Vtb_eth_stats_core)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir
